// ==== testbench/ifetch_patterns.txt ====
// program words from @00, one per line, address 0x1000 + 4 * index
// test records from @40: name(ascii) mode(0 steady, 1 random) start miss_point miss_pc count
// pairs are fetched in 8-byte steps from each start, so loop branches sit at a pair head
@00
a0000013 // 1000
a0010013 // 1004
a0020013 // 1008
a0030013 // 100c
00100063 // 1010 forward branch +16, falls through
a0050013 // 1014
a0060013 // 1018
a0070013 // 101c
a0080013 // 1020
a0090013 // 1024
a00a0013 // 1028
a00b0013 // 102c
a00c0013 // 1030 loop a top
a00d0013 // 1034
a00e0013 // 1038
a00f0013 // 103c
fff00063 // 1040 back -16 to 1030
a0110013 // 1044 younger slot, dropped on loop back
a0120013 // 1048 loop b top
a0130013 // 104c
fff80063 // 1050 back -8 to 1048
a0150013 // 1054
00200063 // 1058 forward +32 inside loop c, falls through
a0170013 // 105c
a0180013 // 1060
a0190013 // 1064
a01a0013 // 1068
a01b0013 // 106c
ffe80063 // 1070 back -24 to 1058
a01d0013 // 1074
@40
73657130 00000000 00001000 ffffffff 00000000 0000000c // seq0 straight run from reset
6c6f6f70 00000000 00001000 ffffffff 00000000 00000018 // loop into loop a, no stalls
726e6430 00000001 00001000 ffffffff 00000000 0000001e // rnd0 random hit and queue room
726e6431 00000001 00001048 ffffffff 00000000 00000010 // rnd1 short loop b
6d697330 00000001 00001000 00000005 00001058 00000014 // mis0 miss into loop c
6d697331 00000001 00001030 00000009 00001000 00000014 // mis1 miss out of loop a
6d697332 00000000 00001058 0000000a 00001048 00000010 // mis2 miss without stalls
00000000 00000000 00000000 00000000 00000000 00000000 // end of list

// ==== all.f ====
hdl/ifetch_pkg.sv
hdl/fetch_pc.sv
hdl/fetch_buffers.sv
hdl/branch_scan.sv
hdl/enqueue_ctrl.sv
hdl/ifetch_top.sv
testbench/tb_ifetch.sv

// ==== Bender.yml ====
package:
  name: ifetch

sources:
  - files:
      - hdl/ifetch_pkg.sv
      - hdl/fetch_pc.sv
      - hdl/fetch_buffers.sv
      - hdl/branch_scan.sv
      - hdl/enqueue_ctrl.sv
      - hdl/ifetch_top.sv
  - target: test
    files:
      - testbench/tb_ifetch.sv

// ==== testbench/tb_ifetch.sv ====
// fetch stage testbench: clock, reset, program memory model, random back-pressure
// reference stream walker, queue model, checks and watchdog

`timescale 1ns/1ps

module tb_ifetch import ifetch_pkg::*; ();

	localparam pc_t START_PC = 32'h0000_1000;   // reset address handed to the DUT
	localparam int RST_CYCLES = 5;
	localparam int PROG_WORDS = 64;             // program window in words
	localparam int REC_BASE = 64;               // first word of the test records
	localparam int REC_WORDS = 6;               // name, mode, start, miss point, miss pc, count
	localparam int MAX_TESTS = 10;
	localparam int MEM_WORDS = REC_BASE + REC_WORDS * MAX_TESTS;
	localparam logic [31:0] NO_MISS = 32'hffff_ffff;
	localparam logic [6:0] BR_OPCODE = 7'h63;

	logic clk;
	logic rst;
	icache_resp_t icache;
	logic [1:0] iq_free;
	redirect_t miss;
	pc_t pc;
	fetch_slot_t fb0;
	fetch_slot_t fb1;
	logic branchback;

	logic [31:0] mem [0:MEM_WORDS-1];   // program words, then test records
	logic [31:0] cur_name;              // four ascii chars
	pc_t exp_pc;                        // walker: next pc the queue should see
	int unsigned accepted;              // slots taken by the queue model
	int unsigned n_tests;
	int unsigned limit_cycles;          // 0 until the records are counted
	int unsigned seed_val;
	int unsigned rnd;

	ifetch_top #(
		.RESET_PC(START_PC)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.icache(icache),
		.iq_free(iq_free),
		.miss(miss),
		.pc(pc),
		.fb0(fb0),
		.fb1(fb1),
		.branchback(branchback)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;      // 4 ns period
	end

	// ========================================
	// program memory and decode
	// ========================================
	// words nobody wrote: plain ops whose upper bits mix in every address bit
	function automatic logic [31:0] fill_word(input pc_t addr);
		return {addr[24:0] ^ addr[31:7], 7'h13};
	endfunction

	function automatic logic [31:0] prog_word(input pc_t addr);
		logic [31:0] idx;
		idx = (addr - START_PC) >> 2;   // below START_PC wraps out of the window
		if (idx < PROG_WORDS)
			return mem[idx];
		else
			return fill_word(addr);
	endfunction

	// branch opcode with the sign bit of the displacement set
	function automatic logic loops_back(input logic [31:0] word);
		return (word[6:0] == BR_OPCODE) && word[31];
	endfunction

	// ========================================
	// checks
	// ========================================
	task automatic expect_equal(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH test %s: %s expected %h actual %h",
				cur_name, what, expected, actual);
			$display(">>> FAIL");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// one slot goes into the queue: compare with the walker, then step it
	task automatic accept_slot(input fetch_slot_t s);
		logic [31:0] word;
		shortint disp;
		word = prog_word(exp_pc);
		expect_equal("enqueued pc", exp_pc, s.pc);
		expect_equal("enqueued insn", word, s.insn);
		disp = word[31:16];
		if (loops_back(word))
			exp_pc = exp_pc + int'(disp);   // backward branch, go to its target
		else
			exp_pc = exp_pc + 32'd4;        // forward branch falls through too
		accepted++;
	endtask

	// ========================================
	// one test record
	// ========================================
	task automatic run_test(input int rec);
		logic [31:0] mode;
		pc_t start_pc;
		logic [31:0] miss_at;
		pc_t miss_pc;
		logic [31:0] n_check;
		logic missed;
		logic first;
		logic exp_bb;
		logic take0;
		logic take1;
		cur_name = mem[REC_BASE + rec * REC_WORDS];
		mode = mem[REC_BASE + rec * REC_WORDS + 1];     // 0 = no stalls, 1 = random
		start_pc = mem[REC_BASE + rec * REC_WORDS + 2];
		miss_at = mem[REC_BASE + rec * REC_WORDS + 3];
		miss_pc = mem[REC_BASE + rec * REC_WORDS + 4];
		n_check = mem[REC_BASE + rec * REC_WORDS + 5];
		accepted = 0;
		missed = 1'b0;
		first = 1'b1;

		rst = 1'b1;
		icache = '0;
		iq_free = 2'b00;
		miss = '0;
		repeat (RST_CYCLES) @(negedge clk);
		expect_equal("fb0.v in reset", 32'd0, fb0.v);
		expect_equal("fb1.v in reset", 32'd0, fb1.v);
		expect_equal("branchback in reset", 32'd0, branchback);
		expect_equal("pc in reset", START_PC, pc);
		rst = 1'b0;
		exp_pc = start_pc;

		// every pass runs at a falling edge, the DUT takes it on the next rising one
		while (accepted < n_check) begin
			miss = '0;
			if (first && start_pc != START_PC) begin
				miss.valid = 1'b1;          // steer the empty stage to the start pc
				miss.pc = start_pc;
				iq_free = 2'b00;
				icache.hit = 1'b0;
			end else if (!missed && accepted >= miss_at) begin
				miss.valid = 1'b1;
				miss.pc = miss_pc;
				iq_free = 2'b00;            // queue takes nothing in the miss cycle
				icache.hit = 1'b0;
				exp_pc = miss_pc;           // older work must never show up again
				missed = 1'b1;
			end else if (mode == 0) begin
				icache.hit = 1'b1;
				iq_free = 2'b11;
			end else begin
				rnd = $urandom;
				icache.hit = rnd[3:2] != 2'b00; // hit three times out of four
				iq_free = rnd[1:0];
			end
			icache.insn0 = prog_word(pc);
			icache.insn1 = prog_word(pc + 32'd4);
			first = 1'b0;

			// oldest live head slot decides branchback
			if (fb0.v)
				exp_bb = loops_back(fb0.insn);
			else
				exp_bb = fb1.v & loops_back(fb1.insn);
			expect_equal("branchback", exp_bb, branchback);

			// queue model: tail0 for the first slot, tail1 as well for a second one
			take0 = fb0.v & iq_free[0];
			if (fb0.v)
				take1 = fb1.v & iq_free[0] & iq_free[1] & ~loops_back(fb0.insn);
			else
				take1 = fb1.v & iq_free[0];
			if (take0)
				accept_slot(fb0);
			if (take1)
				accept_slot(fb1);
			@(negedge clk);
		end

		if (miss_at != NO_MISS && !missed) begin
			$display("test %s ended before its miss pulse was sent", cur_name);
			$display(">>> FAIL");
			$fatal(1, "miss point never reached");
		end
		miss = '0;
		iq_free = 2'b00;
		icache.hit = 1'b0;
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial begin
		int unsigned total;
		rst = 1'b1;
		icache = '0;
		iq_free = 2'b00;
		miss = '0;
		limit_cycles = 0;
		seed_val = 32'hc774d85f;
		rnd = $urandom(seed_val);       // seed once for the whole run

		for (int i = 0; i < MEM_WORDS; i++) begin
			if (i < PROG_WORDS)
				mem[i] = fill_word(START_PC + i * 4);
			else
				mem[i] = '0;
		end
		$readmemh("testbench/ifetch_patterns.txt", mem);

		// a zero name ends the record list
		n_tests = 0;
		total = 0;
		while (n_tests < MAX_TESTS && mem[REC_BASE + n_tests * REC_WORDS] != 0) begin
			total = total + mem[REC_BASE + n_tests * REC_WORDS + 5] * 6 + 40;
			n_tests++;
		end

		if (n_tests == 0) begin
			$display("no test records found in the pattern file");
			$display(">>> FAIL");
			$fatal(1, "nothing to run");
		end else begin
			limit_cycles = total;
			for (int t = 0; t < n_tests; t++)
				run_test(t);
			$display(">>> PASS");
			$finish;
		end
	end

	// watchdog, budget scales with the instruction count of each record
	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: tests still running after %0d cycles", limit_cycles);
		$display(">>> FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== hdl/ifetch_top.sv ====
// instruction fetch stage top level
// pc, ping-pong buffers, branch scan and enqueue control

`timescale 1ns/1ps

module ifetch_top import ifetch_pkg::*; #(
	parameter pc_t RESET_PC = 32'h0000_1000
) (
	input  logic clk,
	input  logic rst,
	input  icache_resp_t icache,
	input  logic [1:0] iq_free,
	input  redirect_t miss,
	output pc_t pc,
	output fetch_slot_t fb0,
	output fetch_slot_t fb1,
	output logic branchback
);

	// ========================================
	// internal wires
	// ========================================
	pc_t backpc;
	logic [1:0] deq;
	logic flip;
	logic load_en;
	logic load_pair;
	logic discard_young;
	logic flush;
	logic redirect_back;
	logic pair_ab_empty;
	logic pair_cd_empty;

	fetch_pc #(
		.RESET_PC(RESET_PC)
	) pc0 (
		.clk(clk),
		.rst(rst),
		.load_en(load_en),
		.redirect_back(redirect_back),
		.backpc(backpc),
		.miss(miss),
		.pc(pc)
	);

	fetch_buffers fbuf0 (
		.clk(clk),
		.rst(rst),
		.icache(icache),
		.pc(pc),
		.load_en(load_en),
		.load_pair(load_pair),
		.flip(flip),
		.discard_young(discard_young),
		.flush(flush),
		.deq(deq),
		.fb0(fb0),
		.fb1(fb1),
		.pair_ab_empty(pair_ab_empty),
		.pair_cd_empty(pair_cd_empty)
	);

	branch_scan bscan0 (
		.fb0(fb0),
		.fb1(fb1),
		.branchback(branchback),
		.backpc(backpc)
	);

	enqueue_ctrl ectl0 (
		.clk(clk),
		.rst(rst),
		.fb0_v(fb0.v),
		.fb1_v(fb1.v),
		.branchback(branchback),
		.hit(icache.hit),
		.iq_free(iq_free),
		.miss_valid(miss.valid),
		.pair_ab_empty(pair_ab_empty),
		.pair_cd_empty(pair_cd_empty),
		.deq(deq),
		.flip(flip),
		.load_en(load_en),
		.load_pair(load_pair),
		.discard_young(discard_young),
		.flush(flush),
		.redirect_back(redirect_back)
	);

endmodule

// ==== hdl/enqueue_ctrl.sv ====
// enqueue decision, head flip and refill request
// branch back and miss handling for the fetch buffers

`timescale 1ns/1ps

module enqueue_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic fb0_v,
	input  logic fb1_v,
	input  logic branchback,
	input  logic hit,
	input  logic [1:0] iq_free,  // bit 0 tail0 free, bit 1 tail1 free
	input  logic miss_valid,
	input  logic pair_ab_empty,
	input  logic pair_cd_empty,
	output logic [1:0] deq,
	output logic flip,
	output logic load_en,
	output logic load_pair,
	output logic discard_young,
	output logic flush,
	output logic redirect_back
);

	logic take0, take1;
	logic branch_taken;          // slot holding the backward branch leaves
	logic head_left;             // some head slot still live after this edge

	// ========================================
	// enqueue table
	// ========================================
	always_comb begin
		take0 = fb0_v & iq_free[0];
		// second slot needs tail1 too when the first one is also going in
		take1 = fb1_v & (fb0_v ? (iq_free[0] & iq_free[1]) : iq_free[0]);
		// branch sits in fb0: fb1 is younger work and gets dropped, not queued
		if (branchback && fb0_v)
			take1 = 1'b0;
		deq = {take1, take0};

		branch_taken = fb0_v ? take0 : take1;
		head_left = (fb0_v & ~take0) | (fb1_v & ~take1);
	end

	// ========================================
	// pointer, refill, redirect
	// ========================================
	always_comb begin
		flip = (fb0_v | fb1_v) & ~head_left; // head goes empty on this edge

		// refill an empty pair; A/B wins when both are empty
		load_en = hit & ~miss_valid & ~branchback & (pair_ab_empty | pair_cd_empty);
		load_pair = ~pair_ab_empty;

		// loop back only once the branch itself is in the queue
		redirect_back = branchback & branch_taken & ~miss_valid;
		discard_young = redirect_back;
		flush = miss_valid;
	end

	// a flip brings up a pair that is fully loaded or fully empty
	// so a lone valid second slot can only come from a partial dequeue
	a_head_pair_state : assert property (
		@(posedge clk) disable iff (rst)
		(fb1_v && !fb0_v) |-> !$past(flip)
	) else $error("head pair shows second slot only right after a flip");

endmodule

// ==== hdl/branch_scan.sv ====
// backward branch detect on the head pair
// target adder for the oldest valid head slot

`timescale 1ns/1ps

module branch_scan import ifetch_pkg::*; (
	input  fetch_slot_t fb0,
	input  fetch_slot_t fb1,
	output logic branchback,     // oldest valid head slot loops back
	output pc_t backpc           // its target
);

	fetch_slot_t oldest;         // first valid slot in program order
	logic oldest_bb;

	// ========================================
	// decode
	// ========================================
	always_comb begin
		// fb0 is older whenever it is live, otherwise fb1 is the oldest
		if (fb0.v) begin
			oldest = fb0;
		end else begin
			oldest = fb1;
		end
		oldest_bb = is_back_branch(oldest.insn);
		branchback = oldest.v & oldest_bb; // nothing live, nothing to redirect
	end

	// ========================================
	// target adder
	// ========================================
	// only sampled when branchback is set
	assign backpc = oldest.pc + branch_disp(oldest.insn);

endmodule

// ==== hdl/fetch_buffers.sv ====
// four fetch slots in two ping-pong pairs, head pointer
// refill, dequeue clear, discard and flush, head pair output mux

`timescale 1ns/1ps

module fetch_buffers import ifetch_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  icache_resp_t icache,
	input  pc_t pc,              // address of icache.insn0
	input  logic load_en,
	input  logic load_pair,      // 0 = A/B, 1 = C/D
	input  logic flip,
	input  logic discard_young,
	input  logic flush,
	input  logic [1:0] deq,      // bit 0 first head slot, bit 1 second
	output fetch_slot_t fb0,
	output fetch_slot_t fb1,
	output logic pair_ab_empty,
	output logic pair_cd_empty
);

	// slot order A, B, C, D; index bit 1 picks the pair
	fetch_slot_t [3:0] slot_q;
	logic head_cd;               // head pair pointer, 0 = A/B

	assign pair_ab_empty = ~slot_q[0].v & ~slot_q[1].v;
	assign pair_cd_empty = ~slot_q[2].v & ~slot_q[3].v;

	// ========================================
	// slot storage
	// ========================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < 4; i++) begin
				slot_q[i] <= '{1'b0, '0, NOP_INSN};
			end
		end else if (flush) begin
			for (int i = 0; i < 4; i++) begin
				slot_q[i].v <= 1'b0;     // branch miss kills everything
			end
		end else begin
			// slots accepted by the issue queue
			if (deq[0])
				slot_q[{head_cd, 1'b0}].v <= 1'b0;
			if (deq[1])
				slot_q[{head_cd, 1'b1}].v <= 1'b0;
			if (discard_young) begin
				// everything fetched after the backward branch
				slot_q[{head_cd, 1'b1}].v <= 1'b0;
				slot_q[{~head_cd, 1'b0}].v <= 1'b0;
				slot_q[{~head_cd, 1'b1}].v <= 1'b0;
			end else if (load_en) begin
				slot_q[{load_pair, 1'b0}] <= '{1'b1, pc, icache.insn0};
				slot_q[{load_pair, 1'b1}] <= '{1'b1, pc + INSN_LEN, icache.insn1};
			end
		end
	end

	// ========================================
	// head pointer
	// ========================================
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			head_cd <= 1'b0;
		end else if (flush || discard_young) begin
			head_cd <= 1'b0;           // restart from A/B
		end else if (load_en && pair_ab_empty && pair_cd_empty) begin
			head_cd <= 1'b0;           // cold refill goes to A/B, make it the head
		end else if (flip) begin
			head_cd <= ~head_cd;       // head drained, younger pair moves up
		end
	end

	// head pair onto the issue side
	assign fb0 = head_cd ? slot_q[2] : slot_q[0];
	assign fb1 = head_cd ? slot_q[3] : slot_q[1];

	// the controller picks the target pair from the empty flags
	a_refill_empty_pair : assert property (
		@(posedge clk) disable iff (rst)
		load_en |-> (load_pair ? pair_cd_empty : pair_ab_empty)
	) else $error("refill aimed at a pair that still holds a valid slot");

endmodule

// ==== hdl/fetch_pc.sv ====
// program counter of the fetch stage
// next address from miss, branch back or sequential advance

`timescale 1ns/1ps

module fetch_pc import ifetch_pkg::*; #(
	parameter pc_t RESET_PC = 32'h0000_1000
) (
	input  logic clk,
	input  logic rst,
	input  logic load_en,       // pair refilled this edge, step past both words
	input  logic redirect_back, // backward branch leaves the head this edge
	input  pc_t backpc,
	input  redirect_t miss,
	output pc_t pc
);

	localparam pc_t PAIR_STEP = INSN_LEN << 1; // two instructions per refill

	// ========================================
	// pc register
	// ========================================
	// priority: back end miss first, it overrides anything the front end saw
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= RESET_PC;
		end else if (miss.valid) begin
			pc <= miss.pc;              // restart at the mispredicted target
		end else if (redirect_back) begin
			pc <= backpc;               // loop back to the branch target
		end else if (load_en) begin
			pc <= pc + PAIR_STEP;       // sequential fetch
		end
		// no hit or no room: hold
	end

	// every source of a new pc must keep word alignment
	// miss comes from the back end and backpc from the branch adder
	a_pc_aligned : assert property (
		@(posedge clk) disable iff (rst)
		(pc & (INSN_LEN - 32'd1)) == '0
	) else $error("fetch pc lost instruction alignment");

endmodule

// ==== hdl/ifetch_pkg.sv ====
// fetch stage types: address, instruction and slot structs
// opcode constants plus backward-branch and displacement helpers

package ifetch_pkg;

	// ========================================
	// basic widths
	// ========================================
	typedef logic [31:0] pc_t;          // byte address
	typedef logic [31:0] insn_t;        // opcode in [6:0], displacement in [31:16]
	typedef logic signed [15:0] disp_t; // byte displacement of a branch

	localparam pc_t INSN_LEN = 32'd4;        // bytes per instruction
	localparam logic [6:0] OP_BRANCH = 7'h63;
	localparam insn_t NOP_INSN = 32'h0000_0000; // opcode 0, never a branch

	// ========================================
	// grouped signals
	// ========================================
	typedef struct packed {
		logic v;      // slot holds a live instruction
		pc_t pc;
		insn_t insn;
	} fetch_slot_t;

	typedef struct packed {
		logic hit;    // both words below are good this cycle
		insn_t insn0; // word at pc
		insn_t insn1; // word at pc + 4
	} icache_resp_t;

	typedef struct packed {
		logic valid;  // single-cycle pulse
		pc_t pc;      // restart address
	} redirect_t;

	// sign-extended displacement, ready to add to a pc
	function automatic pc_t branch_disp(insn_t insn);
		disp_t disp;
		disp = insn[31:16];
		return {{16{disp[15]}}, disp};
	endfunction

	// branch with a negative displacement, i.e. a loop closing branch
	function automatic logic is_back_branch(insn_t insn);
		disp_t disp;
		disp = insn[31:16];
		return (insn[6:0] == OP_BRANCH) && disp[15];
	endfunction

endpackage
